// ==== run.sh ====
#!/bin/sh
# Build and run with Verilator, pass only if the pass message is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module nkmd_cpu_tb \
    -f src.f -o sim_nkmd_cpu \
    && ./obj_dir/sim_nkmd_cpu | tee /dev/stderr | grep -q 'All tests passed!' \
    || exit 1

// ==== src.f ====
verilog/nkmd_pkg.sv
verilog/nkmd_fetch.sv
verilog/nkmd_decode.sv
verilog/nkmd_regfile.sv
verilog/nkmd_mem_stage.sv
verilog/nkmd_execute.sv
verilog/nkmd_cpu.sv
verif/nkmd_cpu_asserts.sv
verif/nkmd_cpu_tb.sv

// ==== verif/nkmd_cpu_asserts.sv ====
module nkmd_cpu_asserts (
    input logic            clk,
    input logic            rst,
    input nkmd_pkg::word_t p_addr_i,
    input logic            r_we_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    // Writeback register is cleared by the first reset edge
    assert property (@(posedge clk) rst |=> !r_we_i)
        else begin
            fail_count++;
            $error("r_we_o high during reset");
        end

    assert property (@(posedge clk) $fell(rst) |-> p_addr_i == '0)
        else begin
            fail_count++;
            $error("p_addr_o not zero in the first cycle after reset");
        end

    assert property (@(posedge clk) disable iff (rst) !$isunknown(r_we_i))
        else begin
            fail_count++;
            $error("r_we_o is unknown");
        end

endmodule

bind nkmd_cpu nkmd_cpu_asserts u_asserts (
    .clk      (clk),
    .rst      (rst),
    .p_addr_i (p_addr_o),
    .r_we_i   (r_we_o)
);

// ==== verif/nkmd_cpu_tb.sv ====
module nkmd_cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 64;

    logic            clk = 1'b0;
    logic            rst;
    nkmd_pkg::word_t p_data = '0;
    nkmd_pkg::word_t p_addr;
    nkmd_pkg::word_t r_rdata = '0;
    nkmd_pkg::word_t r_wdata;
    nkmd_pkg::word_t r_addr;
    logic            r_we;
    nkmd_pkg::inst_t prog [64];
    nkmd_pkg::word_t dmem [256];
    integer          seed = 32'h023115ad;

    nkmd_cpu DUT (
        .clk      (clk),
        .rst      (rst),
        .p_data_i (p_data),
        .p_addr_o (p_addr),
        .r_data_i (r_rdata),
        .r_data_o (r_wdata),
        .r_addr_o (r_addr),
        .r_we_o   (r_we)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    // Both memories answer half a cycle after the address settles
    always @(negedge clk) begin
        p_data <= prog[p_addr[5:0]];
        if (r_we) begin
            dmem[r_addr[7:0]] <= r_wdata;
        end
        r_rdata <= dmem[r_addr[7:0]];
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input nkmd_pkg::word_t got,
                              input nkmd_pkg::word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input nkmd_pkg::word_t got,
                              input nkmd_pkg::word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                $time, name, got, exp));
        end
    endtask

    function automatic nkmd_pkg::inst_t make_inst(input logic jmp, input nkmd_pkg::mwsel_t mw,
            input logic tread, input nkmd_pkg::regsel_t rd, input nkmd_pkg::alu_op_t alu,
            input nkmd_pkg::regsel_t rs, input logic immen, input logic [15:0] imm);
        return nkmd_pkg::inst_t'({jmp, mw, tread, rd, alu, rs, immen, imm});
    endfunction

    function automatic nkmd_pkg::word_t sext16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic nkmd_pkg::word_t alu_model(input nkmd_pkg::alu_op_t op,
            input nkmd_pkg::word_t s, input nkmd_pkg::word_t t);
        case (op)
            nkmd_pkg::ALU_ADD: return s + t;
            nkmd_pkg::ALU_SUB: return s - t;
            nkmd_pkg::ALU_OR:  return s | t;
            nkmd_pkg::ALU_AND: return s & t;
            nkmd_pkg::ALU_XOR: return s ^ t;
            default:           return '0;
        endcase
    endfunction

    task automatic begin_reset();
        rst = 1'b1;
        @(negedge clk);
    endtask

    task automatic end_reset();
        repeat (9) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic clear_memories();
        for (int i = 0; i < 64; i++) begin
            prog[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = 32'h9e3779b9 * (i + 1);
        end
    endtask

    task automatic load_imm(input int slot, input nkmd_pkg::regsel_t rd, input logic [15:0] imm);
        prog[slot] = make_inst(1'b0, nkmd_pkg::MW_NO, 1'b0, rd, nkmd_pkg::ALU_ADD,
                               nkmd_pkg::REG_C0, 1'b1, imm);
    endtask

    task automatic wait_store(input nkmd_pkg::word_t addr, input nkmd_pkg::word_t data);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!r_we && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!r_we) begin
            abort_run("Timed out waiting for a store on the R bus");
        end
        check_addr("r_addr_o", r_addr, addr);
        check_word("r_data_o", r_wdata, data);
    endtask

    task automatic expect_no_store(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (r_we) begin
                abort_run($sformatf("Unexpected store to address %h at %0t", r_addr, $time));
            end
        end
    endtask

    task automatic wait_pc(input nkmd_pkg::word_t addr);
        int cycles;
        cycles = 0;
        while (p_addr !== addr && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (p_addr !== addr) begin
            abort_run("Timed out waiting for the program counter to reach its address");
        end
    endtask

    task automatic fetch_in_order();
        begin_reset();
        clear_memories();
        end_reset();
        for (int i = 0; i < 8; i++) begin
            check_addr("p_addr_o", p_addr, i);
            expect_no_store(1);
        end
    endtask

    // Stores a op b to the address in c, one store per op
    task automatic store_op_results(input int first, input int count);
        logic [15:0] imm_a;
        logic [15:0] imm_b;
        imm_a = 16'h8000 | 16'($random(seed));
        imm_b = 16'($random(seed));
        begin_reset();
        clear_memories();
        load_imm(1, nkmd_pkg::REG_A, imm_a);
        load_imm(2, nkmd_pkg::REG_B, imm_b);
        load_imm(3, nkmd_pkg::REG_C, 16'h0040);
        // rt field selects b
        for (int i = 0; i < count; i++) begin
            prog[7 + i] = make_inst(1'b0, nkmd_pkg::MW_R, 1'b0, nkmd_pkg::REG_C,
                                    nkmd_pkg::alu_op_t'(first + i), nkmd_pkg::REG_A,
                                    1'b0, 16'h0200);
        end
        end_reset();
        for (int i = 0; i < count; i++) begin
            wait_store(32'h40, alu_model(nkmd_pkg::alu_op_t'(first + i),
                                         sext16(imm_a), sext16(imm_b)));
        end
    endtask

    task automatic load_then_add();
        logic [15:0]     imm_s;
        nkmd_pkg::word_t word;
        imm_s = 16'($random(seed));
        word  = $random(seed);
        begin_reset();
        clear_memories();
        dmem[8'h30] = word;
        load_imm(1, nkmd_pkg::REG_A, imm_s);
        load_imm(2, nkmd_pkg::REG_C, 16'h0050);
        prog[6] = make_inst(1'b0, nkmd_pkg::MW_R, 1'b1, nkmd_pkg::REG_C, nkmd_pkg::ALU_ADD,
                            nkmd_pkg::REG_A, 1'b1, 16'h0030);
        end_reset();
        wait_store(32'h50, sext16(imm_s) + word);
    endtask

    task automatic jump_over_code();
        logic [15:0] imm_v;
        imm_v = 16'($random(seed));
        begin_reset();
        clear_memories();
        load_imm(1, nkmd_pkg::REG_C, 16'h0060);
        load_imm(2, nkmd_pkg::REG_A, imm_v);
        prog[6] = make_inst(1'b1, nkmd_pkg::MW_NO, 1'b0, nkmd_pkg::REG_C0, nkmd_pkg::ALU_ADD,
                            nkmd_pkg::REG_C0, 1'b0, 16'd40);
        // Slot 8 sits in the delay slots, slot 10 is skipped
        prog[8] = make_inst(1'b0, nkmd_pkg::MW_R, 1'b0, nkmd_pkg::REG_C, nkmd_pkg::ALU_ADD,
                            nkmd_pkg::REG_A, 1'b1, 16'h0000);
        prog[10] = make_inst(1'b0, nkmd_pkg::MW_R, 1'b0, nkmd_pkg::REG_C, nkmd_pkg::ALU_ADD,
                             nkmd_pkg::REG_A, 1'b1, 16'h0001);
        end_reset();
        wait_pc(32'd6);
        for (int i = 7; i <= 9; i++) begin
            @(negedge clk);
            check_addr("p_addr_o", p_addr, i);
        end
        @(negedge clk);
        check_addr("p_addr_o", p_addr, 32'd40);
        wait_store(32'h60, sext16(imm_v));
        expect_no_store(12);
    endtask

    initial begin
        rst = 1'b1;
        fetch_in_order();
        store_op_results(0, 5);
        store_op_results(5, 3);
        load_then_add();
        jump_over_code();
        if (DUT.u_asserts.fail_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            abort_run("A bound assertion on the DUT ports failed");
        end
    end

endmodule

// ==== verilog/nkmd_cpu.sv ====
module nkmd_cpu (
    input  logic             clk,
    input  logic             rst,
    input  nkmd_pkg::word_t  p_data_i,
    output nkmd_pkg::word_t  p_addr_o,
    input  nkmd_pkg::word_t  r_data_i,
    output nkmd_pkg::word_t  r_data_o,
    output nkmd_pkg::word_t  r_addr_o,
    output logic             r_we_o
);

    nkmd_pkg::inst_t   inst;
    nkmd_pkg::dcd_t    dcd;
    nkmd_pkg::ex_t     ex;
    nkmd_pkg::wb_t     wb;
    nkmd_pkg::jmp_t    jmp;
    nkmd_pkg::word_t   rs_val;
    nkmd_pkg::word_t   rt_val;
    nkmd_pkg::word_t   rd_val;
    nkmd_pkg::regsel_t rf_wr_sel;
    nkmd_pkg::word_t   rf_wr_val;

    nkmd_fetch u_fetch (
        .clk      (clk),
        .rst      (rst),
        .jmp_i    (jmp),
        .p_data_i (p_data_i),
        .p_addr_o (p_addr_o),
        .inst_o   (inst)
    );

    nkmd_decode u_decode (
        .clk    (clk),
        .rst    (rst),
        .inst_i (inst),
        .dcd_o  (dcd)
    );

    // Selects come straight off the decode register
    nkmd_regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .rs_sel_i (dcd.rs),
        .rt_sel_i (dcd.rt),
        .rd_sel_i (dcd.rd),
        .rs_val_o (rs_val),
        .rt_val_o (rt_val),
        .rd_val_o (rd_val),
        .wr_sel_i (rf_wr_sel),
        .wr_val_i (rf_wr_val)
    );

    nkmd_mem_stage u_mem (
        .clk         (clk),
        .rst         (rst),
        .dcd_i       (dcd),
        .rs_val_i    (rs_val),
        .rt_val_i    (rt_val),
        .rd_val_i    (rd_val),
        .wb_i        (wb),
        .ex_o        (ex),
        .rf_wr_sel_o (rf_wr_sel),
        .rf_wr_val_o (rf_wr_val),
        .r_data_i    (r_data_i),
        .r_addr_o    (r_addr_o),
        .r_data_o    (r_data_o),
        .r_we_o      (r_we_o)
    );

    nkmd_execute u_execute (
        .clk   (clk),
        .rst   (rst),
        .ex_i  (ex),
        .wb_o  (wb),
        .jmp_o (jmp)
    );

endmodule

// ==== verilog/nkmd_decode.sv ====
module nkmd_decode (
    input  logic             clk,
    input  logic             rst,
    input  nkmd_pkg::inst_t  inst_i,
    output nkmd_pkg::dcd_t   dcd_o
);

    nkmd_pkg::dcd_t dcd_d;
    nkmd_pkg::dcd_t dcd_q;
    logic           rst_d_q;

    always_comb begin
        dcd_d.rs     = inst_i.rs;
        dcd_d.rt     = inst_i.imm_lo.rt;
        dcd_d.rd     = inst_i.rd;
        dcd_d.alu    = inst_i.alu;
        dcd_d.immen  = inst_i.immen;
        dcd_d.jmp    = inst_i.jmp;

        // Sign bit extends both offsets
        dcd_d.imm    = {{17{inst_i.sign}}, inst_i.imm_lo};
        dcd_d.jmprel = {{24{inst_i.sign}}, inst_i.imm_lo.jmprel_lo};

        // Jumps never read or write memory
        if (inst_i.jmp) begin
            dcd_d.tread = 1'b0;
            dcd_d.mwsel = nkmd_pkg::MW_NO;
        end else begin
            dcd_d.tread = inst_i.tread;
            dcd_d.mwsel = inst_i.mwsel;
        end
    end

    always_ff @(posedge clk) begin
        rst_d_q <= rst;
    end

    // Held at no-op through reset and one cycle past it
    always_ff @(posedge clk) begin
        if (rst || rst_d_q) begin
            dcd_q <= '0;
        end else begin
            dcd_q <= dcd_d;
        end
    end

    assign dcd_o = dcd_q;

endmodule

// ==== verilog/nkmd_execute.sv ====
module nkmd_execute (
    input  logic             clk,
    input  logic             rst,
    input  nkmd_pkg::ex_t    ex_i,
    output nkmd_pkg::wb_t    wb_o,
    output nkmd_pkg::jmp_t   jmp_o
);

    nkmd_pkg::word_t alu_res;
    nkmd_pkg::wb_t   wb_q;
    nkmd_pkg::jmp_t  jmp_q;

    always_comb begin
        case (ex_i.alu)
            nkmd_pkg::ALU_ADD: alu_res = ex_i.s + ex_i.t;
            nkmd_pkg::ALU_SUB: alu_res = ex_i.s - ex_i.t;
            nkmd_pkg::ALU_OR:  alu_res = ex_i.s | ex_i.t;
            nkmd_pkg::ALU_AND: alu_res = ex_i.s & ex_i.t;
            nkmd_pkg::ALU_XOR: alu_res = ex_i.s ^ ex_i.t;
            // Clamp and mul not implemented
            default:           alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_q <= '0;
        end else begin
            wb_q.rd     <= ex_i.rd;
            wb_q.val    <= alu_res;
            wb_q.rd_val <= ex_i.rd_val;
            wb_q.mwsel  <= ex_i.mwsel;
        end
    end

    // Jump target relative to the rd value
    always_ff @(posedge clk) begin
        if (rst) begin
            jmp_q <= '0;
        end else begin
            jmp_q.en     <= ex_i.jmp;
            jmp_q.target <= ex_i.rd_val + ex_i.jmprel;
        end
    end

    assign wb_o  = wb_q;
    assign jmp_o = jmp_q;

endmodule

// ==== verilog/nkmd_fetch.sv ====
module nkmd_fetch (
    input  logic             clk,
    input  logic             rst,
    input  nkmd_pkg::jmp_t   jmp_i,
    input  nkmd_pkg::word_t  p_data_i,
    output nkmd_pkg::word_t  p_addr_o,
    output nkmd_pkg::inst_t  inst_o
);

    nkmd_pkg::word_t pc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= '0;
        end else if (jmp_i.en) begin
            pc_q <= jmp_i.target;
        end else begin
            pc_q <= pc_q + 32'd1;
        end
    end

    assign p_addr_o = pc_q;
    // Program memory answers in the same cycle
    assign inst_o = nkmd_pkg::inst_t'(p_data_i);

endmodule

// ==== verilog/nkmd_mem_stage.sv ====
module nkmd_mem_stage (
    input  logic                clk,
    input  logic                rst,
    input  nkmd_pkg::dcd_t      dcd_i,
    input  nkmd_pkg::word_t     rs_val_i,
    input  nkmd_pkg::word_t     rt_val_i,
    input  nkmd_pkg::word_t     rd_val_i,
    input  nkmd_pkg::wb_t       wb_i,
    output nkmd_pkg::ex_t       ex_o,
    output nkmd_pkg::regsel_t   rf_wr_sel_o,
    output nkmd_pkg::word_t     rf_wr_val_o,
    input  nkmd_pkg::word_t     r_data_i,
    output nkmd_pkg::word_t     r_addr_o,
    output nkmd_pkg::word_t     r_data_o,
    output logic                r_we_o
);

    nkmd_pkg::word_t ld_addr;
    logic            store;
    nkmd_pkg::ex_t   ex_d;
    nkmd_pkg::ex_t   ex_q;

    assign ld_addr = dcd_i.immen ? dcd_i.imm : rt_val_i;

    // Store from writeback wins the R bus over a load address
    assign store    = (wb_i.mwsel == nkmd_pkg::MW_R);
    assign r_we_o   = store;
    assign r_addr_o = store ? wb_i.rd_val : ld_addr;
    assign r_data_o = wb_i.val;

    // Register write only when nothing goes to memory
    assign rf_wr_sel_o = (wb_i.mwsel == nkmd_pkg::MW_NO) ? wb_i.rd : nkmd_pkg::REG_C0;
    assign rf_wr_val_o = wb_i.val;

    always_comb begin
        ex_d.s      = rs_val_i;
        // t is the loaded word, or the address itself
        ex_d.t      = dcd_i.tread ? r_data_i : ld_addr;
        ex_d.alu    = dcd_i.alu;
        ex_d.rd     = dcd_i.rd;
        ex_d.rd_val = rd_val_i;
        ex_d.mwsel  = dcd_i.mwsel;
        ex_d.jmp    = dcd_i.jmp;
        ex_d.jmprel = dcd_i.jmprel;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_q <= '0;
        end else begin
            ex_q <= ex_d;
        end
    end

    assign ex_o = ex_q;

endmodule

// ==== verilog/nkmd_pkg.sv ====
package nkmd_pkg;

    typedef logic [31:0] word_t;

    // Register slots, c0/ra/pc read as zero
    typedef enum logic [3:0] {
        REG_C0 = 4'h0,
        REG_A  = 4'h1,
        REG_B  = 4'h2,
        REG_C  = 4'h3,
        REG_D  = 4'h4,
        REG_E  = 4'h5,
        REG_F  = 4'h6,
        REG_G  = 4'h7,
        REG_H  = 4'h8,
        REG_I  = 4'h9,
        REG_J  = 4'ha,
        REG_RA = 4'hb,
        REG_SL = 4'hc,
        REG_SH = 4'hd,
        REG_N  = 4'he,
        REG_PC = 4'hf
    } regsel_t;

    typedef enum logic [2:0] {
        ALU_ADD   = 3'd0,
        ALU_SUB   = 3'd1,
        ALU_OR    = 3'd2,
        ALU_AND   = 3'd3,
        ALU_XOR   = 3'd4,
        ALU_RESV  = 3'd5,
        ALU_CLAMP = 3'd6,
        ALU_MUL   = 3'd7
    } alu_op_t;

    typedef enum logic [1:0] {
        MW_NO = 2'd0,
        MW_R  = 2'd1,
        MW_T  = 2'd2,
        MW_C  = 2'd3
    } mwsel_t;

    // Low immediate bits, rt and jump offset overlap it
    typedef struct packed {
        logic [2:0] top;
        regsel_t    rt;
        logic [7:0] jmprel_lo;
    } imm_lo_t;

    typedef struct packed {
        logic    jmp;
        mwsel_t  mwsel;
        logic    tread;
        regsel_t rd;
        alu_op_t alu;
        regsel_t rs;
        logic    immen;
        logic    sign;
        imm_lo_t imm_lo;
    } inst_t;

    typedef struct packed {
        regsel_t rs;
        regsel_t rt;
        regsel_t rd;
        alu_op_t alu;
        word_t   imm;
        word_t   jmprel;
        logic    tread;
        mwsel_t  mwsel;
        logic    immen;
        logic    jmp;
    } dcd_t;

    typedef struct packed {
        word_t   s;
        word_t   t;
        alu_op_t alu;
        regsel_t rd;
        word_t   rd_val;
        mwsel_t  mwsel;
        logic    jmp;
        word_t   jmprel;
    } ex_t;

    typedef struct packed {
        regsel_t rd;
        word_t   val;
        word_t   rd_val;
        mwsel_t  mwsel;
    } wb_t;

    typedef struct packed {
        logic  en;
        word_t target;
    } jmp_t;

endpackage

// ==== verilog/nkmd_regfile.sv ====
module nkmd_regfile (
    input  logic                clk,
    input  logic                rst,
    input  nkmd_pkg::regsel_t   rs_sel_i,
    input  nkmd_pkg::regsel_t   rt_sel_i,
    input  nkmd_pkg::regsel_t   rd_sel_i,
    output nkmd_pkg::word_t     rs_val_o,
    output nkmd_pkg::word_t     rt_val_o,
    output nkmd_pkg::word_t     rd_val_o,
    input  nkmd_pkg::regsel_t   wr_sel_i,
    input  nkmd_pkg::word_t     wr_val_i
);

    nkmd_pkg::word_t regs [16];

    // c0, ra and pc have no storage behind them
    function automatic logic is_real(nkmd_pkg::regsel_t sel);
        return !(sel inside {nkmd_pkg::REG_C0, nkmd_pkg::REG_RA, nkmd_pkg::REG_PC});
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (is_real(wr_sel_i)) begin
            regs[wr_sel_i] <= wr_val_i;
        end
    end

    assign rs_val_o = is_real(rs_sel_i) ? regs[rs_sel_i] : '0;
    assign rt_val_o = is_real(rt_sel_i) ? regs[rt_sel_i] : '0;
    assign rd_val_o = is_real(rd_sel_i) ? regs[rd_sel_i] : '0;

endmodule
